/* lcd_cmd_table.svh */
`ifndef LCD_CMD_TABLE_SVH
`define LCD_CMD_TABLE_SVH

// entry: {flags, delay[27:24]}, delay[23:16], delay[15:8], delay[7:0], data
// data mode entries carry a length, then the characters
localparam int CMD_ROM_DEPTH = 99;

localparam logic [7:0] F_CMD = 8'h70;  // pulse, backlight, nibble
localparam logic [7:0] F_CHR = 8'hF0;  // as above plus data mode

localparam logic [6:0] ADDR_INIT = 7'd0;
localparam logic [6:0] ADDR_PROMPT = 7'd23;
localparam logic [6:0] ADDR_LOW = 7'd44;
localparam logic [6:0] ADDR_HIGH = 7'd62;
localparam logic [6:0] ADDR_WIN = 7'd81;

function automatic logic [7:0] cmd_rom_byte(input logic [6:0] addr);
	logic [0:CMD_ROM_DEPTH*8-1] rom;
	rom = {
		F_CMD, 8'h00, 8'h06, 8'h40, 8'h01,  // clear, 1600 us
		F_CHR, 8'h00, 8'h00, 8'h32, 8'd8,
		"PRESS OK",
		8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
		F_CMD, 8'h00, 8'h06, 8'h40, 8'h01,
		F_CHR, 8'h00, 8'h00, 8'h32, 8'd6,
		"GUESS:",
		8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
		F_CMD, 8'h00, 8'h00, 8'h32, 8'hC0,  // cursor to line 2
		F_CHR, 8'h00, 8'h00, 8'h32, 8'd3,
		"LOW",
		8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
		F_CMD, 8'h00, 8'h00, 8'h32, 8'hC0,
		F_CHR, 8'h00, 8'h00, 8'h32, 8'd4,
		"HIGH",
		8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
		F_CMD, 8'h00, 8'h06, 8'h40, 8'h01,
		F_CHR, 8'h00, 8'h00, 8'h32, 8'd3,
		"WIN",
		8'h00, 8'h00, 8'h00, 8'h00, 8'h00
	};
	if (addr >= CMD_ROM_DEPTH)
		return 8'h00;
	return rom[addr*8 +: 8];
endfunction

function automatic logic [6:0] msg_addr(input guess_pkg::msg_e m);
	case (m)
		guess_pkg::MSG_PROMPT: return ADDR_PROMPT;
		guess_pkg::MSG_LOW: return ADDR_LOW;
		guess_pkg::MSG_HIGH: return ADDR_HIGH;
		guess_pkg::MSG_WIN: return ADDR_WIN;
		default: return ADDR_INIT;
	endcase
endfunction

`endif

/* guess_pkg.sv */
package guess_pkg;

	// NEC command bytes of the 17-key remote
	localparam logic [7:0] KEY_0 = 8'h19;
	localparam logic [7:0] KEY_1 = 8'h45;
	localparam logic [7:0] KEY_2 = 8'h46;
	localparam logic [7:0] KEY_3 = 8'h47;
	localparam logic [7:0] KEY_4 = 8'h44;
	localparam logic [7:0] KEY_5 = 8'h40;
	localparam logic [7:0] KEY_6 = 8'h43;
	localparam logic [7:0] KEY_7 = 8'h07;
	localparam logic [7:0] KEY_8 = 8'h15;
	localparam logic [7:0] KEY_9 = 8'h09;
	localparam logic [7:0] KEY_OK = 8'h1C;

	typedef enum logic [1:0] {
		KEY_NONE,
		KEY_DIGIT,
		KEY_ENTER,
		KEY_OTHER
	} key_kind_e;

	typedef enum logic [2:0] {
		G_BOOT,
		G_WAIT_OK,
		G_ENTRY,
		G_SHOW,   // result or prompt on screen
		G_ECHO    // digit echo on screen
	} game_state_e;

	typedef enum logic [2:0] {
		S_IDLE,
		S_FLAGS,
		S_DELAY,
		S_DATA,
		S_CHAR,
		S_WAIT
	} seq_state_e;

	typedef enum logic [2:0] {
		MSG_INIT,
		MSG_PROMPT,
		MSG_LOW,
		MSG_HIGH,
		MSG_WIN,
		MSG_ECHO
	} msg_e;

	// bit positions in the flag nibble, same order as the writer mode bits
	localparam int FLAG_DATAMODE = 3;
	localparam int FLAG_PULSE = 2;
	localparam int FLAG_BACKLIGHT = 1;
	localparam int FLAG_NIBBLE = 0;

	localparam logic [31:0] LFSR_TAPS = 32'h80200003; // galois, shift right

endpackage

/* lcd_seq_if.sv */
`timescale 1ns/1ns

// request path from the game FSM to the LCD command sequencer
interface lcd_seq_if;
	logic start;                 // one cycle, only while idle is high
	guess_pkg::msg_e msg;
	logic [7:0] echo_char;       // ascii, used with MSG_ECHO
	logic idle;

	modport game (
		output start,
		output msg,
		output echo_char,
		input idle
	);

	modport seq (
		input start,
		input msg,
		input echo_char,
		output idle
	);
endinterface

/* ir_key_decode.sv */
`timescale 1ns/1ns

module ir_key_decode (
	input logic CLK,
	input logic rst_n,
	input logic [7:0] i_ir_data,
	input logic i_ir_ready,
	output logic o_key_valid,
	output guess_pkg::key_kind_e o_key_kind,
	output logic [3:0] o_digit
);

	guess_pkg::key_kind_e kind;
	logic [3:0] digit;

	always_comb begin
		kind = guess_pkg::KEY_DIGIT;
		digit = 4'd0;
		case (i_ir_data)
			guess_pkg::KEY_0: digit = 4'd0;
			guess_pkg::KEY_1: digit = 4'd1;
			guess_pkg::KEY_2: digit = 4'd2;
			guess_pkg::KEY_3: digit = 4'd3;
			guess_pkg::KEY_4: digit = 4'd4;
			guess_pkg::KEY_5: digit = 4'd5;
			guess_pkg::KEY_6: digit = 4'd6;
			guess_pkg::KEY_7: digit = 4'd7;
			guess_pkg::KEY_8: digit = 4'd8;
			guess_pkg::KEY_9: digit = 4'd9;
			guess_pkg::KEY_OK: kind = guess_pkg::KEY_ENTER;
			default: kind = guess_pkg::KEY_OTHER;  // arrows, * and # land here
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			o_key_valid <= 1'b0;
			o_key_kind <= guess_pkg::KEY_NONE;
		end else begin
			o_key_valid <= i_ir_ready;
			o_key_kind <= i_ir_ready ? kind : guess_pkg::KEY_NONE;
		end
	end

	// digit only matters alongside a valid event
	always_ff @(posedge CLK) begin
		if (i_ir_ready)
			o_digit <= digit;
	end

endmodule

/* guess_game.sv */
`timescale 1ns/1ns

module guess_game #(
	parameter logic [31:0] LFSR_SEED = 32'h0000_0001
) (
	input logic CLK,
	input logic rst_n,
	input logic i_key_valid,
	input guess_pkg::key_kind_e i_key_kind,
	input logic [3:0] i_digit,
	lcd_seq_if.game seq
);

	guess_pkg::game_state_e state;
	guess_pkg::msg_e msg_r;
	logic start_r;
	logic [7:0] echo_r;
	logic [31:0] lfsr;
	logic [11:0] secret;    // hundreds in the top nibble
	logic [11:0] entry;
	logic [1:0] n_digits;   // saturates at 3
	logic seq_ready;
	logic key_ok;
	logic key_digit;
	logic key_enter;

	function automatic logic [3:0] fold(input logic [3:0] n);
		return (n >= 4'd10) ? n - 4'd10 : n;
	endfunction

	assign seq.start = start_r;
	assign seq.msg = msg_r;
	assign seq.echo_char = echo_r;

	// idle is still high in the cycle the request goes out
	assign seq_ready = seq.idle && !start_r;
	assign key_ok = i_key_valid && seq_ready &&
		(state == guess_pkg::G_WAIT_OK || state == guess_pkg::G_ENTRY);
	assign key_digit = key_ok && (i_key_kind == guess_pkg::KEY_DIGIT);
	assign key_enter = key_ok && (i_key_kind == guess_pkg::KEY_ENTER);

	// one step per accepted digit or OK
	always_ff @(posedge CLK) begin
		if (!rst_n)
			lfsr <= LFSR_SEED;
		else if (key_digit || key_enter)
			lfsr <= lfsr[0] ? (lfsr >> 1) ^ guess_pkg::LFSR_TAPS : lfsr >> 1;
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state <= guess_pkg::G_BOOT;
			start_r <= 1'b0;
			n_digits <= 2'd0;
		end else begin
			start_r <= 1'b0;
			case (state)
				guess_pkg::G_BOOT: begin
					start_r <= 1'b1;
					msg_r <= guess_pkg::MSG_INIT;
					state <= guess_pkg::G_WAIT_OK;
				end
				guess_pkg::G_WAIT_OK: begin
					if (key_enter) begin
						// secret from the lfsr value before this step
						secret <= {fold(lfsr[3:0]), fold(lfsr[7:4]), fold(lfsr[11:8])};
						start_r <= 1'b1;
						msg_r <= guess_pkg::MSG_PROMPT;
						state <= guess_pkg::G_SHOW;
					end
				end
				guess_pkg::G_ENTRY: begin
					if (key_digit) begin
						entry <= {entry[7:0], i_digit};
						if (n_digits != 2'd3)
							n_digits <= n_digits + 2'd1;
						echo_r <= {4'h3, i_digit};  // ascii '0'..'9'
						start_r <= 1'b1;
						msg_r <= guess_pkg::MSG_ECHO;
						state <= guess_pkg::G_ECHO;
					end else if (key_enter && n_digits == 2'd3) begin
						start_r <= 1'b1;
						if (entry < secret)
							msg_r <= guess_pkg::MSG_LOW;
						else if (entry > secret)
							msg_r <= guess_pkg::MSG_HIGH;
						else
							msg_r <= guess_pkg::MSG_WIN;
						state <= guess_pkg::G_SHOW;
					end
				end
				guess_pkg::G_ECHO: begin
					if (seq_ready)
						state <= guess_pkg::G_ENTRY;
				end
				guess_pkg::G_SHOW: begin
					if (seq_ready) begin
						if (msg_r == guess_pkg::MSG_WIN) begin
							state <= guess_pkg::G_WAIT_OK;  // new round on next OK
						end else begin
							entry <= 12'd0;
							n_digits <= 2'd0;
							state <= guess_pkg::G_ENTRY;
						end
					end
				end
				default: state <= guess_pkg::G_BOOT;
			endcase
		end
	end

endmodule

/* lcd_cmd_seq.sv */
`timescale 1ns/1ns

module lcd_cmd_seq #(
	parameter int TICKS_PER_USEC = 12
) (
	input logic CLK,
	input logic rst_n,
	lcd_seq_if.seq seq,
	output logic o_lcd_enable,
	output logic [7:0] o_lcd_data,
	output logic [3:0] o_lcd_mode,
	input logic i_lcd_busy
);

	`include "lcd_cmd_table.svh"

	localparam logic [27:0] ECHO_USEC = 28'd50;
	localparam logic [3:0] ECHO_FLAGS = 4'(
		(1 << guess_pkg::FLAG_DATAMODE) | (1 << guess_pkg::FLAG_PULSE) |
		(1 << guess_pkg::FLAG_BACKLIGHT) | (1 << guess_pkg::FLAG_NIBBLE));

	guess_pkg::seq_state_e state;
	guess_pkg::seq_state_e after_wait;  // where to go once the delay ran out
	logic [6:0] rom_addr;
	logic [7:0] rom_byte;
	logic [3:0] flags;
	logic [27:0] delay_usec;
	logic [1:0] dly_cnt;
	logic [7:0] str_len;
	logic [31:0] wait_cnt;
	logic [31:0] wait_limit;

	assign rom_byte = cmd_rom_byte(rom_addr);
	assign wait_limit = 32'(delay_usec) * 32'(TICKS_PER_USEC);
	assign seq.idle = (state == guess_pkg::S_IDLE);

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state <= guess_pkg::S_IDLE;
			after_wait <= guess_pkg::S_IDLE;
			o_lcd_enable <= 1'b0;
			wait_cnt <= 32'd0;
		end else begin
			o_lcd_enable <= 1'b0;
			case (state)
				guess_pkg::S_IDLE: begin
					if (seq.start) begin
						if (seq.msg == guess_pkg::MSG_ECHO) begin
							// single character, no rom walk
							o_lcd_data <= seq.echo_char;
							o_lcd_mode <= ECHO_FLAGS;
							o_lcd_enable <= 1'b1;
							delay_usec <= ECHO_USEC;
							after_wait <= guess_pkg::S_IDLE;
							state <= guess_pkg::S_WAIT;
						end else begin
							rom_addr <= msg_addr(seq.msg);
							state <= guess_pkg::S_FLAGS;
						end
					end
				end
				guess_pkg::S_FLAGS: begin
					{flags, delay_usec[27:24]} <= rom_byte;
					rom_addr <= rom_addr + 7'd1;
					dly_cnt <= 2'd0;
					state <= guess_pkg::S_DELAY;
				end
				guess_pkg::S_DELAY: begin
					delay_usec[23:0] <= {delay_usec[15:0], rom_byte};  // msb first
					rom_addr <= rom_addr + 7'd1;
					dly_cnt <= dly_cnt + 2'd1;
					if (dly_cnt == 2'd2)
						state <= guess_pkg::S_DATA;
				end
				guess_pkg::S_DATA: begin
					if (delay_usec == 28'd0) begin
						state <= guess_pkg::S_IDLE;  // end marker
					end else if (flags[guess_pkg::FLAG_DATAMODE]) begin
						str_len <= rom_byte;
						rom_addr <= rom_addr + 7'd1;
						state <= (rom_byte == 8'd0) ? guess_pkg::S_FLAGS : guess_pkg::S_CHAR;
					end else begin
						o_lcd_data <= rom_byte;  // command byte
						o_lcd_mode <= flags;
						o_lcd_enable <= 1'b1;
						rom_addr <= rom_addr + 7'd1;
						after_wait <= guess_pkg::S_FLAGS;
						state <= guess_pkg::S_WAIT;
					end
				end
				guess_pkg::S_CHAR: begin
					o_lcd_data <= rom_byte;
					o_lcd_mode <= flags;
					o_lcd_enable <= 1'b1;
					rom_addr <= rom_addr + 7'd1;
					str_len <= str_len - 8'd1;
					after_wait <= (str_len == 8'd1) ? guess_pkg::S_FLAGS : guess_pkg::S_CHAR;
					state <= guess_pkg::S_WAIT;
				end
				guess_pkg::S_WAIT: begin
					// skip the strobe cycle, busy shows up after it
					if (!i_lcd_busy && !o_lcd_enable) begin
						if (wait_cnt == wait_limit - 32'd1) begin
							wait_cnt <= 32'd0;
							state <= after_wait;
						end else begin
							wait_cnt <= wait_cnt + 32'd1;
						end
					end
				end
				default: state <= guess_pkg::S_IDLE;
			endcase
		end
	end

endmodule

/* guess_top.sv */
`timescale 1ns/1ns

module guess_top #(
	parameter int TICKS_PER_USEC = 12,              // 12 MHz board clock
	parameter logic [31:0] LFSR_SEED = 32'h5EED_C0DE
) (
	input logic CLK,
	input logic rst_n,
	input logic [7:0] i_ir_data,
	input logic i_ir_ready,
	output logic o_lcd_enable,
	output logic [7:0] o_lcd_data,
	output logic [3:0] o_lcd_mode,
	input logic i_lcd_busy
);

	logic key_valid;
	guess_pkg::key_kind_e key_kind;
	logic [3:0] key_digit;

	lcd_seq_if seq_bus ();

	ir_key_decode u_decode (
		.CLK(CLK),
		.rst_n(rst_n),
		.i_ir_data(i_ir_data),
		.i_ir_ready(i_ir_ready),
		.o_key_valid(key_valid),
		.o_key_kind(key_kind),
		.o_digit(key_digit)
	);

	guess_game #(.LFSR_SEED(LFSR_SEED)) u_game (
		.CLK(CLK),
		.rst_n(rst_n),
		.i_key_valid(key_valid),
		.i_key_kind(key_kind),
		.i_digit(key_digit),
		.seq(seq_bus.game)
	);

	lcd_cmd_seq #(.TICKS_PER_USEC(TICKS_PER_USEC)) u_seq (
		.CLK(CLK),
		.rst_n(rst_n),
		.seq(seq_bus.seq),
		.o_lcd_enable(o_lcd_enable),
		.o_lcd_data(o_lcd_data),
		.o_lcd_mode(o_lcd_mode),
		.i_lcd_busy(i_lcd_busy)
	);

endmodule

/* tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
	parameter int RESET_CYCLES = 16
) (
	output logic CLK,
	output logic rst_n
);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;  // 10 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1 rst_n = 1'b1;
	end

endmodule

/* guess_tb.sv */
`timescale 1ns/1ns

module guess_tb;

	localparam logic [31:0] SEED = 32'h5EED_C0DE;
	localparam int MAX_PAT = 64;

	logic CLK;
	logic rst_n;
	logic [7:0] ir_data;
	logic ir_ready;
	logic lcd_enable;
	logic [7:0] lcd_data;
	logic [3:0] lcd_mode;
	logic lcd_busy;

	string pat_name[MAX_PAT];
	logic [7:0] pat_code[MAX_PAT];
	string pat_out[MAX_PAT];
	int n_pat;
	int n_tests;
	int n_fail;
	int cycles;
	int limit;
	int busy_left;
	logic [11:0] got[$];  // mode and byte of each strobe seen by the writer model

	// reference model of the game
	int m_state;          // 0 waiting for OK, 1 digit entry
	logic [31:0] m_lfsr;
	int sec[3];           // hundreds first
	int ent;
	int ndig;

	logic pend;
	string pend_exp;
	string pend_name;

	tb_clock u_clock (.CLK(CLK), .rst_n(rst_n));

	guess_top #(.TICKS_PER_USEC(1), .LFSR_SEED(SEED)) UUT (
		.CLK(CLK),
		.rst_n(rst_n),
		.i_ir_data(ir_data),
		.i_ir_ready(ir_ready),
		.o_lcd_enable(lcd_enable),
		.o_lcd_data(lcd_data),
		.o_lcd_mode(lcd_mode),
		.i_lcd_busy(lcd_busy)
	);

	function automatic int digit_of(input logic [7:0] code);
		logic [7:0] codes[10];
		codes = '{8'h19, 8'h45, 8'h46, 8'h47, 8'h44, 8'h40, 8'h43, 8'h07, 8'h15, 8'h09};
		for (int i = 0; i < 10; i++)
			if (codes[i] == code)
				return i;
		return -1;
	endfunction

	function automatic logic [7:0] code_of_digit(input int d);
		logic [7:0] codes[10];
		codes = '{8'h19, 8'h45, 8'h46, 8'h47, 8'h44, 8'h40, 8'h43, 8'h07, 8'h15, 8'h09};
		return codes[d];
	endfunction

	function automatic int fold4(input logic [3:0] n);
		return (n >= 4'd10) ? int'(n) - 10 : int'(n);
	endfunction

	// predict outcome and LCD text of one accepted key
	// commands show as [hh], characters as themselves
	task automatic model_key(input logic [7:0] code, output string outc, output string exp);
		int d;
		int guess;
		d = digit_of(code);
		outc = "NONE";
		exp = "";
		if (d < 0 && code != 8'h1C)
			return;  // unknown code, lfsr stays
		if (m_state == 0) begin
			if (code == 8'h1C) begin
				sec[0] = fold4(m_lfsr[3:0]);
				sec[1] = fold4(m_lfsr[7:4]);
				sec[2] = fold4(m_lfsr[11:8]);
				m_state = 1;
				ent = 0;
				ndig = 0;
				outc = "PROMPT";
				exp = "[01]GUESS:";
			end
		end else if (d >= 0) begin
			ent = (ent % 100) * 10 + d;
			if (ndig < 3)
				ndig++;
			outc = "ECHO";
			exp = $sformatf("%0d", d);
		end else if (ndig == 3) begin
			guess = sec[0] * 100 + sec[1] * 10 + sec[2];
			if (ent < guess) begin
				outc = "LOW";
				exp = "[c0]LOW";
			end else if (ent > guess) begin
				outc = "HIGH";
				exp = "[c0]HIGH";
			end else begin
				outc = "WIN";
				exp = "[01]WIN";
				m_state = 0;
			end
			if (outc != "WIN") begin
				ent = 0;
				ndig = 0;
			end
		end
		m_lfsr = m_lfsr[0] ? (m_lfsr >> 1) ^ 32'h80200003 : m_lfsr >> 1;
	endtask

	task automatic send_key(input logic [7:0] code);
		@(posedge CLK);
		#1;
		ir_data = code;
		ir_ready = 1'b1;
		@(posedge CLK);
		#1;
		ir_ready = 1'b0;
	endtask

	// collect the pending text, then wait for the sequencer to go idle
	task automatic finish_pending();
		string act;
		if (!pend)
			return;
		while (got.size() == 0) begin
			@(posedge CLK);
			#1;
		end
		while (UUT.seq_bus.idle !== 1'b1) begin
			@(posedge CLK);
			#1;
		end
		act = "";
		foreach (got[i]) begin
			if (got[i][11:8] == 4'hF)
				act = $sformatf("%s%c", act, got[i][7:0]);
			else if (got[i][11:8] == 4'h7)
				act = $sformatf("%s[%02h]", act, got[i][7:0]);
			else
				act = $sformatf("%s{%h:%02h}", act, got[i][11:8], got[i][7:0]);  // odd mode
		end
		n_tests++;
		if (act != pend_exp) begin
			$display("CHECK FAILED %s: expected \"%s\" actual \"%s\"", pend_name, pend_exp, act);
			n_fail++;
		end else begin
			$display("test %s ok: \"%s\"", pend_name, act);
		end
		got.delete();
		pend = 1'b0;
	endtask

	task automatic read_patterns();
		int fd;
		string line;
		string nm;
		string oc;
		logic [7:0] code;
		fd = $fopen("guess_patterns.txt", "r");
		if (fd == 0) begin
			$display("cannot open guess_patterns.txt");
			n_fail++;
		end else begin
			while (!$feof(fd) && n_pat < MAX_PAT) begin
				if ($fgets(line, fd) == 0)
					continue;
				if (line.len() < 3 || line.getc(0) == 8'h23)
					continue;  // comment or blank
				if ($sscanf(line, "%s %h %s", nm, code, oc) == 3) begin
					pat_name[n_pat] = nm;
					pat_code[n_pat] = code;
					pat_out[n_pat] = oc;
					n_pat++;
				end
			end
			$fclose(fd);
		end
	endtask

	// LCD writer model, busy for 1..8 cycles after each strobe
	initial begin
		lcd_busy = 1'b0;
		busy_left = 0;
	end

	always @(posedge CLK) begin
		#1;
		if (busy_left > 0) begin
			busy_left--;
			if (busy_left == 0)
				lcd_busy = 1'b0;
		end
		if (lcd_enable === 1'b1) begin
			got.push_back({lcd_mode, lcd_data});
			busy_left = int'($urandom_range(8, 1));
			lcd_busy = 1'b1;
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout: no LCD completion after %0d cycles", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin
		string outc;
		string exp;
		logic [7:0] code;
		logic busy_key;
		logic last_out;  // previous key started an LCD sequence
		ir_data = 8'h00;
		ir_ready = 1'b0;
		cycles = 0;
		limit = 0;
		n_pat = 0;
		n_tests = 0;
		n_fail = 0;
		void'($urandom(32'ha419b65e));
		read_patterns();
		limit = (n_pat + 1) * 2000;
		m_state = 0;
		m_lfsr = SEED;
		pend = 1'b1;
		pend_exp = "[01]PRESS OK";
		pend_name = "reset_banner";
		last_out = 1'b1;
		wait (rst_n === 1'b1);
		for (int i = 0; i < n_pat; i++) begin
			busy_key = last_out && (pat_out[i] == "NONE");
			if (busy_key) begin
				while (got.size() == 0) begin  // sequence is running now
					@(posedge CLK);
					#1;
				end
			end else begin
				finish_pending();
			end
			code = pat_code[i];
			if (code >= 8'hA0 && code <= 8'hA2)
				code = code_of_digit(sec[int'(code - 8'hA0)]);  // secret digit marker
			if (busy_key) begin
				exp = "";
			end else begin
				model_key(code, outc, exp);
				if (outc != pat_out[i]) begin
					$display("test %s: pattern says %s but the model predicts %s",
						pat_name[i], pat_out[i], outc);
					n_fail++;
				end
			end
			send_key(code);
			last_out = (exp != "");
			if (exp != "") begin
				pend = 1'b1;
				pend_exp = exp;
				pend_name = pat_name[i];
			end else begin
				n_tests++;
				$display("test %s ok: no output expected", pat_name[i]);
			end
		end
		finish_pending();
		repeat (100) @(posedge CLK);
		#1;
		if (got.size() != 0 || UUT.seq_bus.idle !== 1'b1) begin
			$display("LCD output appeared after the last test");
			n_fail++;
		end
		$display("tests run %0d, failures %0d", n_tests, n_fail);
		if (n_fail == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* guess_patterns.txt */
# name  key code (hex, A0..A2 = secret digit hundreds..units)  expected outcome
# NONE right after a key with output is sent while that sequence is on the LCD
boot_other_key   0D NONE
boot_digit       45 NONE
round1_ok        1C PROMPT
prompt_busy_key  46 NONE
g1_d0            19 ECHO
echo_busy_key    1C NONE
g1_d1            19 ECHO
g1_d2            19 ECHO
g1_ok            1C LOW
short_d0         45 ECHO
short_ok         1C NONE
g2_d0            09 ECHO
g2_d1            09 ECHO
g2_d2            09 ECHO
g2_ok            1C HIGH
high_busy_key    0D NONE
win_d0           A0 ECHO
win_d1           A1 ECHO
win_d2           A2 ECHO
win_ok           1C WIN
win_busy_key     47 NONE
idle_digit       40 NONE
round2_ok        1C PROMPT
r2_other         16 NONE
r2_d0            19 ECHO
r2_d1            19 ECHO
r2_d2            19 ECHO
r2_low_ok        1C LOW
r2_win_d0        A0 ECHO
r2_win_d1        A1 ECHO
r2_win_d2        A2 ECHO
r2_win_ok        1C WIN

/* flist.f */
+incdir+.
guess_pkg.sv
lcd_seq_if.sv
ir_key_decode.sv
guess_game.sv
lcd_cmd_seq.sv
guess_top.sv
tb_clock.sv
guess_tb.sv

/* run.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module guess_tb -o guess_sim

out=$(./obj_dir/guess_sim)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1
